// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --timing --assert -Wno-fatal
TOP = mmsCoherentTb
FILELIST = mmsCoherence.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== include/mmsCoherence_cfg.svh ====
`ifndef MMS_COHERENCE_CFG_SVH
`define MMS_COHERENCE_CFG_SVH

// core ids run from 1 to this value, id 0 is invalid
`define MMS_N_CORES 4

// 64 lines of one word each
`define MMS_ADDR_WIDTH 6
`define MMS_DATA_WIDTH 32

// base delay in cycles of each return class
`define MMS_DELAY_HIT 2
`define MMS_DELAY_CTC 6
`define MMS_DELAY_MEMORY 10

// credits granted once the clearing sweep is done
`define MMS_OP_CREDITS 1

`endif

// ==== mmsCoherence.f ====
+incdir+include
rtl/mmsProtocolPkg.sv
rtl/mmsReturnPkg.sv
rtl/memAccessIf.sv
rtl/returnIf.sv
rtl/directoryMemory.sv
rtl/memOpController.sv
rtl/returnPath.sv
rtl/mmsCoherentTop.sv
testbench/mmsChecker.sv
testbench/mmsCoherentTb.sv

// ==== rtl/directoryMemory.sv ====
`timescale 1ns/10ps
`include "mmsCoherence_cfg.svh"

module directoryMemory (
  input logic clock,
  input logic reset,
  memAccessIf.memorySide mem
);
  import mmsProtocolPkg::*;

  localparam int LineCount = 1 << `MMS_ADDR_WIDTH;

  dataWordT dataArray [LineCount];
  dirEntryT dirArray [LineCount];

  logic sweeping;
  lineAddrT sweepAddr;

  // clearing sweep, one line per cycle after reset
  always_ff @(posedge clock) begin
    if (reset) begin
      sweeping <= 1'b1;
      sweepAddr <= '0;
    end else if (sweeping) begin
      sweepAddr <= sweepAddr + 1'b1;
      if (sweepAddr == '1) begin
        sweeping <= 1'b0;
      end
    end
  end

  // sweep owns the write port until it is done
  always_ff @(posedge clock) begin
    if (sweeping) begin
      dataArray[sweepAddr] <= '0;
      dirArray[sweepAddr] <= '{state: DirClean, sharers: '0};
    end else if (mem.writeEnable) begin
      dataArray[mem.lineAddr] <= mem.writeData;
      dirArray[mem.lineAddr] <= mem.writeEntry;
    end
  end

  assign mem.readData = dataArray[mem.lineAddr];
  assign mem.readEntry = dirArray[mem.lineAddr];
  assign mem.ready = !sweeping;

  // the controller must hold off until the sweep has finished
  noWriteDuringSweep: assert property (
    @(posedge clock) disable iff (reset)
    mem.writeEnable |-> mem.ready
  );

endmodule

// ==== rtl/memAccessIf.sv ====
`timescale 1ns/10ps

interface memAccessIf;
  import mmsProtocolPkg::*;

  lineAddrT lineAddr;
  dirEntryT readEntry;
  dataWordT readData;
  logic writeEnable;
  dirEntryT writeEntry;
  dataWordT writeData;
  // low until the clearing sweep is done
  logic ready;

  modport controllerSide (
    output lineAddr, writeEnable, writeEntry, writeData,
    input readEntry, readData, ready
  );

  modport memorySide (
    input lineAddr, writeEnable, writeEntry, writeData,
    output readEntry, readData, ready
  );

endinterface

// ==== rtl/memOpController.sv ====
`timescale 1ns/10ps
`include "mmsCoherence_cfg.svh"

module memOpController (
  input logic clock,
  input logic reset,
  input logic opValid,
  input mmsProtocolPkg::coreIdT opDest,
  input mmsProtocolPkg::opKindT opKind,
  input logic opForce,
  input mmsProtocolPkg::lineAddrT opAddr,
  input mmsProtocolPkg::dataWordT opWriteData,
  output logic opCredit,
  memAccessIf.controllerSide mem,
  returnIf.controllerSide ret,
  output logic resendValid,
  output mmsProtocolPkg::coreIdT resendDest,
  output mmsProtocolPkg::resendKindT resendKind,
  output mmsProtocolPkg::lineAddrT resendAddr,
  output logic invalidateValid,
  output mmsProtocolPkg::coreIdT invalidateCore,
  output mmsProtocolPkg::lineAddrT invalidateAddr
);
  import mmsProtocolPkg::*;
  import mmsReturnPkg::*;

  typedef enum logic [2:0] {
    StSweep,
    StGrant,
    StIdle,
    StDecide,
    StReturn,
    StInvalidate
  } ctrlStateT;

  ctrlStateT state;
  logic [3:0] grantCount;

  coreIdT opDestReg;
  opKindT opKindReg;
  logic opForceReg;
  lineAddrT opAddrReg;
  dataWordT opDataReg;

  returnClassT retCls;
  returnItemT retItem;
  sharerMaskT invMask;

  dirEntryT entry;
  sharerMaskT reqBit;
  sharerMaskT otherSharers;
  logic readAllowed;
  logic destValid;
  returnClassT decideCls;
  coreIdT nextInvIndex;

  assign entry = mem.readEntry;
  assign destValid = (opDestReg != '0) && (opDestReg <= coreIdT'(`MMS_N_CORES));
  assign reqBit = sharerMaskT'(1) << (opDestReg - coreIdT'(1));
  assign otherSharers = entry.sharers & ~reqBit;
  assign readAllowed = (entry.state == DirClean) || (entry.state == DirWaiting && opForceReg);

  always_comb begin
    if ((entry.sharers & reqBit) != '0) begin
      decideCls = ClassHit;
    end else if (otherSharers != '0) begin
      decideCls = ClassCacheToCache;
    end else begin
      decideCls = ClassMemory;
    end
  end

  // lowest pending sharer goes first, so cores are walked in rising order
  always_comb begin
    nextInvIndex = '0;
    for (int i = `MMS_N_CORES - 1; i >= 0; i--) begin
      if (invMask[i]) begin
        nextInvIndex = coreIdT'(i);
      end
    end
  end

  // directory and data update, written at the end of the decide cycle
  always_comb begin
    mem.lineAddr = opAddrReg;
    mem.writeEnable = 1'b0;
    mem.writeEntry = entry;
    mem.writeData = mem.readData;
    if (state == StDecide && destValid) begin
      case (opKindReg)
        OpRead: begin
          mem.writeEnable = readAllowed;
          mem.writeEntry = '{state: DirClean, sharers: entry.sharers | reqBit};
        end
        OpExclusiveRead, OpUpgrade: begin
          mem.writeEnable = readAllowed || (opKindReg == OpUpgrade);
          mem.writeEntry = '{state: DirModified, sharers: reqBit};
        end
        OpFlush: begin
          mem.writeEnable = 1'b1;
          mem.writeEntry = '{state: DirClean, sharers: '0};
          mem.writeData = opDataReg;
        end
        OpRequestFlush: begin
          mem.writeEnable = 1'b1;
          mem.writeEntry = '{state: DirWaiting, sharers: entry.sharers};
          mem.writeData = opDataReg;
        end
        default: begin
          mem.writeEnable = 1'b0;
        end
      endcase
    end
  end

  // valid only once the class pipeline can take the item
  assign ret.valid = (state == StReturn) && !ret.stall;
  assign ret.cls = retCls;
  assign ret.item = retItem;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= StSweep;
      grantCount <= '0;
      invMask <= '0;
      opCredit <= 1'b0;
      resendValid <= 1'b0;
      invalidateValid <= 1'b0;
    end else begin
      opCredit <= 1'b0;
      resendValid <= 1'b0;
      invalidateValid <= 1'b0;
      case (state)
        StSweep: begin
          if (mem.ready) begin
            state <= StGrant;
          end
        end
        StGrant: begin
          opCredit <= 1'b1;
          grantCount <= grantCount + 1'b1;
          if (grantCount == 4'(`MMS_OP_CREDITS - 1)) begin
            state <= StIdle;
          end
        end
        StIdle: begin
          if (opValid) begin
            opDestReg <= opDest;
            opKindReg <= opKind;
            opForceReg <= opForce;
            opAddrReg <= opAddr;
            opDataReg <= opWriteData;
            state <= StDecide;
          end
        end
        StDecide: begin
          resendDest <= opDestReg;
          resendAddr <= opAddrReg;
          retCls <= decideCls;
          retItem <= '{dest: opDestReg, data: mem.readData};
          invMask <= (opKindReg == OpRead) ? '0 : otherSharers;
          if (!destValid) begin
            opCredit <= 1'b1;
            state <= StIdle;
          end else if (opKindReg == OpRead || opKindReg == OpExclusiveRead) begin
            if (readAllowed) begin
              state <= StReturn;
            end else begin
              resendValid <= 1'b1;
              resendKind <= ResendRetry;
              opCredit <= 1'b1;
              state <= StIdle;
            end
          end else if (opKindReg == OpUpgrade) begin
            resendValid <= 1'b1;
            resendKind <= ResendGrantExclusive;
            state <= StInvalidate;
          end else begin
            // flushes are done with the write of this cycle
            opCredit <= 1'b1;
            state <= StIdle;
          end
        end
        StReturn: begin
          if (!ret.stall) begin
            state <= StInvalidate;
          end
        end
        StInvalidate: begin
          if (invMask == '0) begin
            opCredit <= 1'b1;
            state <= StIdle;
          end else begin
            invalidateValid <= 1'b1;
            invalidateCore <= nextInvIndex + coreIdT'(1);
            invalidateAddr <= opAddrReg;
            invMask <= invMask & ~(sharerMaskT'(1) << nextInvIndex);
          end
        end
        default: begin
          state <= StIdle;
        end
      endcase
    end
  end

  // the requester sends only on a credit, and one credit is out at a time
  opOnlyWhenIdle: assert property (
    @(posedge clock) disable iff (reset)
    opValid |-> state == StIdle
  );

endmodule

// ==== rtl/mmsCoherentTop.sv ====
`timescale 1ns/10ps

module mmsCoherentTop (
  input logic clock,
  input logic reset,
  input logic opValid,
  input mmsProtocolPkg::coreIdT opDest,
  input mmsProtocolPkg::opKindT opKind,
  input logic opForce,
  input mmsProtocolPkg::lineAddrT opAddr,
  input mmsProtocolPkg::dataWordT opWriteData,
  output logic opCredit,
  output logic resendValid,
  output mmsProtocolPkg::coreIdT resendDest,
  output mmsProtocolPkg::resendKindT resendKind,
  output mmsProtocolPkg::lineAddrT resendAddr,
  output logic invalidateValid,
  output mmsProtocolPkg::coreIdT invalidateCore,
  output mmsProtocolPkg::lineAddrT invalidateAddr,
  output logic returnValid,
  output mmsProtocolPkg::coreIdT returnDest,
  output mmsProtocolPkg::dataWordT returnData
);

  memAccessIf memBus ();
  returnIf retBus ();

  directoryMemory dirMem (
    .clock(clock),
    .reset(reset),
    .mem(memBus.memorySide)
  );

  memOpController controller (
    .clock(clock),
    .reset(reset),
    .opValid(opValid),
    .opDest(opDest),
    .opKind(opKind),
    .opForce(opForce),
    .opAddr(opAddr),
    .opWriteData(opWriteData),
    .opCredit(opCredit),
    .mem(memBus.controllerSide),
    .ret(retBus.controllerSide),
    .resendValid(resendValid),
    .resendDest(resendDest),
    .resendKind(resendKind),
    .resendAddr(resendAddr),
    .invalidateValid(invalidateValid),
    .invalidateCore(invalidateCore),
    .invalidateAddr(invalidateAddr)
  );

  returnPath retPath (
    .clock(clock),
    .reset(reset),
    .ret(retBus.pathSide),
    .returnValid(returnValid),
    .returnDest(returnDest),
    .returnData(returnData)
  );

endmodule

// ==== rtl/mmsProtocolPkg.sv ====
`include "mmsCoherence_cfg.svh"

package mmsProtocolPkg;

  typedef logic [3:0] coreIdT;
  typedef logic [`MMS_ADDR_WIDTH-1:0] lineAddrT;
  typedef logic [`MMS_DATA_WIDTH-1:0] dataWordT;

  typedef enum logic [2:0] {
    OpRead,
    OpExclusiveRead,
    OpUpgrade,
    OpFlush,
    OpRequestFlush
  } opKindT;

  // Waiting marks a line whose owner was asked to flush it
  typedef enum logic [1:0] {
    DirClean,
    DirWaiting,
    DirModified
  } dirStateT;

  // bit i holds core i+1
  typedef logic [`MMS_N_CORES-1:0] sharerMaskT;

  typedef struct packed {
    dirStateT state;
    sharerMaskT sharers;
  } dirEntryT;

  typedef enum logic {
    ResendRetry,
    ResendGrantExclusive
  } resendKindT;

endpackage

// ==== rtl/mmsReturnPkg.sv ====
package mmsReturnPkg;

  // also the merge priority, Hit first
  typedef enum logic [1:0] {
    ClassHit,
    ClassCacheToCache,
    ClassMemory
  } returnClassT;

  typedef struct packed {
    mmsProtocolPkg::coreIdT dest;
    mmsProtocolPkg::dataWordT data;
  } returnItemT;

endpackage

// ==== rtl/returnIf.sv ====
`timescale 1ns/10ps

interface returnIf;
  import mmsReturnPkg::*;

  logic valid;
  returnClassT cls;
  returnItemT item;
  // entry stage of the pipeline selected by cls is blocked
  logic stall;

  modport controllerSide (output valid, cls, item, input stall);

  modport pathSide (input valid, cls, item, output stall);

endinterface

// ==== rtl/returnPath.sv ====
`timescale 1ns/10ps
`include "mmsCoherence_cfg.svh"

module returnPath (
  input logic clock,
  input logic reset,
  returnIf.pathSide ret,
  output logic returnValid,
  output mmsProtocolPkg::coreIdT returnDest,
  output mmsProtocolPkg::dataWordT returnData
);
  import mmsReturnPkg::*;

  localparam int NumClasses = 3;

  logic [NumClasses-1:0] headValid;
  logic [NumClasses-1:0] grant;
  logic [NumClasses-1:0] entryStall;
  returnItemT headItem [NumClasses];
  returnItemT selItem;

  for (genvar c = 0; c < NumClasses; c++) begin : gPipe
    localparam int Depth = (c == 0) ? `MMS_DELAY_HIT :
                           (c == 1) ? `MMS_DELAY_CTC : `MMS_DELAY_MEMORY;

    logic [Depth-1:0] stageValid;
    returnItemT stageItem [Depth];
    logic load;
    logic frozen;

    assign load = ret.valid && (ret.cls == returnClassT'(c));
    // a head that lost arbitration holds the whole pipeline
    assign frozen = stageValid[Depth-1] && !grant[c];
    assign entryStall[c] = frozen && stageValid[0];
    assign headValid[c] = stageValid[Depth-1];
    assign headItem[c] = stageItem[Depth-1];

    always_ff @(posedge clock) begin
      if (reset) begin
        stageValid <= '0;
      end else if (!frozen) begin
        stageValid <= {stageValid[Depth-2:0], load};
      end else if (!stageValid[0]) begin
        stageValid[0] <= load;
      end
    end

    always_ff @(posedge clock) begin
      if (!frozen || !stageValid[0]) begin
        stageItem[0] <= ret.item;
      end
      if (!frozen) begin
        for (int s = 1; s < Depth; s++) begin
          stageItem[s] <= stageItem[s-1];
        end
      end
    end

    // an item offered to a blocked entry stage would be lost
    noLoadWhileBlocked: assert property (
      @(posedge clock) disable iff (reset)
      load |-> !entryStall[c]
    );
  end

  // fixed priority, Hit over CacheToCache over Memory
  assign grant[0] = headValid[0];
  assign grant[1] = headValid[1] && !headValid[0];
  assign grant[2] = headValid[2] && !headValid[0] && !headValid[1];

  always_comb begin
    case (ret.cls)
      ClassHit: ret.stall = entryStall[0];
      ClassCacheToCache: ret.stall = entryStall[1];
      default: ret.stall = entryStall[2];
    endcase
  end

  always_comb begin
    if (grant[0]) begin
      selItem = headItem[0];
    end else if (grant[1]) begin
      selItem = headItem[1];
    end else begin
      selItem = headItem[2];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      returnValid <= 1'b0;
    end else begin
      returnValid <= |grant;
    end
  end

  always_ff @(posedge clock) begin
    returnDest <= selItem.dest;
    returnData <= selItem.data;
  end

endmodule

// ==== testbench/mmsChecker.sv ====
`timescale 1ns/10ps
`include "mmsCoherence_cfg.svh"

module mmsChecker (
  input logic clock,
  input logic reset,
  input logic opValid,
  input mmsProtocolPkg::coreIdT opDest,
  input mmsProtocolPkg::lineAddrT opAddr,
  input logic [1:0] expClass,
  input mmsProtocolPkg::coreIdT expDest,
  input mmsProtocolPkg::dataWordT expData,
  input logic [1:0] expResend,
  input mmsProtocolPkg::sharerMaskT expInvalidate,
  input logic opCredit,
  input logic resendValid,
  input mmsProtocolPkg::coreIdT resendDest,
  input mmsProtocolPkg::resendKindT resendKind,
  input mmsProtocolPkg::lineAddrT resendAddr,
  input logic invalidateValid,
  input mmsProtocolPkg::coreIdT invalidateCore,
  input mmsProtocolPkg::lineAddrT invalidateAddr,
  input logic returnValid,
  input mmsProtocolPkg::coreIdT returnDest,
  input mmsProtocolPkg::dataWordT returnData,
  input logic finishing,
  output int valueErrors,
  output int eventErrors,
  output int pendingReturns,
  output logic reported
);
  import mmsProtocolPkg::*;

  typedef struct {
    coreIdT dest;
    dataWordT data;
    int earliest;
  } expReturnT;

  typedef struct {
    coreIdT dest;
    resendKindT kind;
    lineAddrT addr;
  } expResendT;

  typedef struct {
    coreIdT core;
    lineAddrT addr;
  } expInvalidateT;

  expReturnT returns[$];
  expResendT resends[$];
  expInvalidateT invalidates[$];
  int cycle;
  int heldCredits;
  logic creditSeen;

  // class code 0 hit, 1 cache to cache, 2 memory
  function automatic int minLatency(input logic [1:0] cls);
    case (cls)
      2'd0: return `MMS_DELAY_HIT + 1;
      2'd1: return `MMS_DELAY_CTC + 1;
      default: return `MMS_DELAY_MEMORY + 1;
    endcase
  endfunction

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    if (got !== expected) begin
      $display("ERR %s got %h expected %h at cycle %0d", name, got, expected, cycle);
      valueErrors++;
    end
  endtask

  task automatic acceptOp();
    expReturnT r;
    expResendT s;
    expInvalidateT v;
    if (expClass != 2'd3) begin
      r.dest = expDest;
      r.data = expData;
      r.earliest = cycle + minLatency(expClass);
      returns.push_back(r);
    end
    if (expResend != 2'd2) begin
      s.dest = opDest;
      s.kind = resendKindT'(expResend[0]);
      s.addr = opAddr;
      resends.push_back(s);
    end
    // other sharers are invalidated in rising core order
    for (int i = 0; i < `MMS_N_CORES; i++) begin
      if (expInvalidate[i]) begin
        v.core = coreIdT'(i + 1);
        v.addr = opAddr;
        invalidates.push_back(v);
      end
    end
  endtask

  task automatic matchReturn();
    int found;
    found = -1;
    // prefer an entry whose class delay has already passed
    foreach (returns[i]) begin
      if (found < 0 && returns[i].dest == returnDest && returns[i].data == returnData &&
          returns[i].earliest <= cycle) begin
        found = i;
      end
    end
    foreach (returns[i]) begin
      if (found < 0 && returns[i].dest == returnDest && returns[i].data == returnData) begin
        found = i;
      end
    end
    if (found < 0 && returns.size() == 0) begin
      $display("unexpected return to core %0d at cycle %0d", returnDest, cycle);
      eventErrors++;
    end else if (found < 0) begin
      compareValue("returnDest", 32'(returnDest), 32'(returns[0].dest));
      compareValue("returnData", returnData, returns[0].data);
      returns.delete(0);
    end else begin
      if (cycle < returns[found].earliest) begin
        $display("return to core %0d came at cycle %0d, sooner than its class allows",
                 returnDest, cycle);
        eventErrors++;
      end
      returns.delete(found);
    end
  endtask

  task automatic matchResend();
    expResendT s;
    if (resends.size() == 0) begin
      $display("unexpected resend to core %0d at cycle %0d", resendDest, cycle);
      eventErrors++;
    end else begin
      s = resends.pop_front();
      compareValue("resendDest", 32'(resendDest), 32'(s.dest));
      compareValue("resendKind", 32'(resendKind), 32'(s.kind));
      compareValue("resendAddr", 32'(resendAddr), 32'(s.addr));
    end
  endtask

  task automatic matchInvalidate();
    expInvalidateT v;
    if (invalidates.size() == 0) begin
      $display("unexpected invalidation of core %0d at cycle %0d", invalidateCore, cycle);
      eventErrors++;
    end else begin
      v = invalidates.pop_front();
      compareValue("invalidateCore", 32'(invalidateCore), 32'(v.core));
      compareValue("invalidateAddr", 32'(invalidateAddr), 32'(v.addr));
    end
  endtask

  task automatic reportLeftovers();
    foreach (returns[i]) begin
      $display("missing return to core %0d with data %h", returns[i].dest, returns[i].data);
      eventErrors++;
    end
    foreach (resends[i]) begin
      $display("missing resend to core %0d for line %h", resends[i].dest, resends[i].addr);
      eventErrors++;
    end
    foreach (invalidates[i]) begin
      $display("missing invalidation of core %0d for line %h", invalidates[i].core,
               invalidates[i].addr);
      eventErrors++;
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      cycle = 0;
      heldCredits = 0;
      creditSeen = 1'b0;
      valueErrors = 0;
      eventErrors = 0;
      returns.delete();
      resends.delete();
      invalidates.delete();
      reported <= 1'b0;
      pendingReturns <= 0;
    end else begin
      cycle++;
      // nothing may leave the DUT while the sweep is running
      if (!creditSeen && (resendValid || invalidateValid || returnValid)) begin
        $display("output event before the first credit at cycle %0d", cycle);
        eventErrors++;
      end
      if (opCredit && !creditSeen) begin
        creditSeen = 1'b1;
        if (cycle <= (1 << `MMS_ADDR_WIDTH)) begin
          $display("first credit after %0d cycles, before the sweep could finish", cycle);
          eventErrors++;
        end
      end
      heldCredits = heldCredits + int'(opCredit) - int'(opValid);
      if (heldCredits < 0) begin
        $display("operation sent without a credit at cycle %0d", cycle);
        eventErrors++;
      end else if (heldCredits > `MMS_OP_CREDITS) begin
        $display("DUT granted more credits than allowed at cycle %0d", cycle);
        eventErrors++;
      end
      if (opValid) begin
        acceptOp();
      end
      if (returnValid) begin
        matchReturn();
      end
      if (resendValid) begin
        matchResend();
      end
      if (invalidateValid) begin
        matchInvalidate();
      end
      if (finishing && !reported) begin
        reportLeftovers();
        reported <= 1'b1;
      end
      pendingReturns <= returns.size();
    end
  end

endmodule

// ==== testbench/mmsCoherentTb.sv ====
`timescale 1ns/10ps
`include "mmsCoherence_cfg.svh"

module mmsCoherentTb;
  import mmsProtocolPkg::*;

  typedef struct packed {
    logic [2:0] kind;
    coreIdT dest;
    logic forceFlag;
    lineAddrT addr;
    dataWordT writeData;
    logic [1:0] expClass;
    coreIdT expDest;
    dataWordT expData;
    logic [1:0] expResend;
    sharerMaskT expInvalidate;
  } testLineT;

  logic clock;
  logic reset;
  logic opValid;
  coreIdT opDest;
  opKindT opKind;
  logic opForce;
  lineAddrT opAddr;
  dataWordT opWriteData;
  logic opCredit;
  logic resendValid;
  coreIdT resendDest;
  resendKindT resendKind;
  lineAddrT resendAddr;
  logic invalidateValid;
  coreIdT invalidateCore;
  lineAddrT invalidateAddr;
  logic returnValid;
  coreIdT returnDest;
  dataWordT returnData;

  // expected results travel next to the operation they belong to
  logic [1:0] expClass;
  coreIdT expDest;
  dataWordT expData;
  logic [1:0] expResend;
  sharerMaskT expInvalidate;
  logic finishing;
  int valueErrors;
  int eventErrors;
  int pendingReturns;
  logic reported;

  testLineT tests[$];
  int creditsIn;
  int creditsSpent;
  logic loaded;

  mmsCoherentTop i_dut (.*);

  mmsChecker scoreboard (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    if (reset) begin
      creditsIn <= 0;
    end else if (opCredit) begin
      creditsIn <= creditsIn + 1;
    end
  end

  task automatic loadTests();
    int fd;
    string line;
    logic [31:0] field [10];
    testLineT t;
    fd = $fopen("testbench/mmsCoherent_tests.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        // comment and blank lines do not scan as ten fields
        if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", field[0], field[1], field[2],
                    field[3], field[4], field[5], field[6], field[7], field[8],
                    field[9]) == 10) begin
          t.kind = field[0][2:0];
          t.dest = coreIdT'(field[1]);
          t.forceFlag = field[2][0];
          t.addr = lineAddrT'(field[3]);
          t.writeData = field[4];
          t.expClass = field[5][1:0];
          t.expDest = coreIdT'(field[6]);
          t.expData = field[7];
          t.expResend = field[8][1:0];
          t.expInvalidate = sharerMaskT'(field[9]);
          tests.push_back(t);
        end
      end
      $fclose(fd);
    end
  endtask

  // one operation per credit
  task automatic sendOp(input testLineT t);
    @(posedge clock);
    while (creditsIn == creditsSpent) begin
      @(posedge clock);
    end
    opValid <= 1'b1;
    opKind <= opKindT'(t.kind);
    opDest <= t.dest;
    opForce <= t.forceFlag;
    opAddr <= t.addr;
    opWriteData <= t.writeData;
    expClass <= t.expClass;
    expDest <= t.expDest;
    expData <= t.expData;
    expResend <= t.expResend;
    expInvalidate <= t.expInvalidate;
    creditsSpent++;
    @(posedge clock);
    opValid <= 1'b0;
  endtask

  initial begin
    reset = 1'b1;
    opValid = 1'b0;
    opDest = '0;
    opKind = OpRead;
    opForce = 1'b0;
    opAddr = '0;
    opWriteData = '0;
    expClass = 2'd3;
    expDest = '0;
    expData = '0;
    expResend = 2'd2;
    expInvalidate = '0;
    finishing = 1'b0;
    creditsSpent = 0;
    loaded = 1'b0;
    loadTests();
    if (tests.size() == 0) begin
      $display("no test lines could be read from the tests file");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (3) @(posedge clock);
      reset <= 1'b0;
      foreach (tests[i]) begin
        sendOp(tests[i]);
      end
      // every credit back means every operation has retired
      while (creditsIn < creditsSpent + `MMS_OP_CREDITS) begin
        @(posedge clock);
      end
      for (int n = 0; n < 4 * `MMS_DELAY_MEMORY && pendingReturns != 0; n++) begin
        @(posedge clock);
      end
      // quiet window to catch late extra events
      repeat (`MMS_DELAY_MEMORY + 4) @(posedge clock);
      finishing <= 1'b1;
      while (!reported) begin
        @(posedge clock);
      end
      $display("value errors %0d, event errors %0d", valueErrors, eventErrors);
      if (valueErrors + eventErrors == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

  // budget covers the sweep plus a generous span per operation
  initial begin
    wait (loaded);
    repeat (200 * tests.size() + (1 << `MMS_ADDR_WIDTH) + 20) @(posedge clock);
    $display("watchdog expired, the run did not finish its %0d test lines", tests.size());
    $display("value errors %0d, event errors %0d", valueErrors, eventErrors + 1);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== testbench/mmsCoherent_tests.txt ====
# kind dest force addr wdata | class rdest rdata | resend | invmask (all hex)
# kind 0 read 1 excl 2 upgrade 3 flush 4 reqflush; class 0 hit 1 ctc 2 mem 3 none
# resend 0 retry 1 grant 2 none; invmask bit 0 is core 1
0 1 0 05 00000000 2 1 00000000 2 0
0 1 0 3f 00000000 2 1 00000000 2 0
3 2 0 10 cafe0001 3 0 00000000 2 0
0 1 0 10 00000000 2 1 cafe0001 2 0
0 1 0 10 00000000 0 1 cafe0001 2 0
0 3 0 10 00000000 1 3 cafe0001 2 0
0 4 0 10 00000000 1 4 cafe0001 2 0
1 2 0 10 00000000 1 2 cafe0001 2 d
0 1 0 10 00000000 3 0 00000000 0 0
4 2 0 10 beef0010 3 0 00000000 2 0
0 3 0 10 00000000 3 0 00000000 0 0
0 3 1 10 00000000 1 3 beef0010 2 0
2 1 0 10 00000000 3 0 00000000 1 6
0 0 0 05 00000000 3 0 00000000 2 0
3 1 0 20 11110020 3 0 00000000 2 0
3 1 0 21 22220021 3 0 00000000 2 0
0 1 0 21 00000000 2 1 22220021 2 0
0 2 0 20 00000000 2 2 11110020 2 0
0 3 0 21 00000000 1 3 22220021 2 0
0 3 0 21 00000000 0 3 22220021 2 0
0 2 0 20 00000000 0 2 11110020 2 0
0 4 0 05 00000000 1 4 00000000 2 0
